//--- iwmPkg.sv
package iwmPkg;

	// ==========================================================
	// State pseudo-register bit select, decoded from addr[3:1]
	// ==========================================================
	localparam logic [2:0] regPhase0 = 3'd0;
	localparam logic [2:0] regPhase1 = 3'd1;
	localparam logic [2:0] regPhase2 = 3'd2;
	localparam logic [2:0] regPhase3 = 3'd3;
	localparam logic [2:0] regMotor = 3'd4;
	localparam logic [2:0] regDrive = 3'd5;
	localparam logic [2:0] regQ6 = 3'd6;
	localparam logic [2:0] regQ7 = 3'd7;

	// Latch, async and timer-off set out of reset
	localparam logic [7:0] modeResetValue = 8'h07;

	// Width shared by the read and write bit-cell timers
	localparam int bitTimerW = 6;

	// Read windows in fclk counts, slow mode runs at half rate
	localparam logic [bitTimerW-1:0] oneThreshSlow7 = 6'd14;
	localparam logic [bitTimerW-1:0] oneThreshSlow8 = 6'd16;
	localparam logic [bitTimerW-1:0] oneThreshFast7 = 6'd7;
	localparam logic [bitTimerW-1:0] oneThreshFast8 = 6'd8;
	// No edge for 1.5 cells past the 1 window means a 0
	localparam logic [bitTimerW-1:0] zeroThreshSlow7 = 6'd42;
	localparam logic [bitTimerW-1:0] zeroThreshSlow8 = 6'd48;
	localparam logic [bitTimerW-1:0] zeroThreshFast7 = 6'd21;
	localparam logic [bitTimerW-1:0] zeroThreshFast8 = 6'd24;

	// Last timer value of a write cell, period minus one
	localparam logic [bitTimerW-1:0] writeCellSlow7 = 6'd27;
	localparam logic [bitTimerW-1:0] writeCellSlow8 = 6'd31;
	localparam logic [bitTimerW-1:0] writeCellFast7 = 6'd13;
	localparam logic [bitTimerW-1:0] writeCellFast8 = 6'd15;
	// Start value puts the first toggle one cell after Q7 rises
	localparam logic [bitTimerW-1:0] writeTimerStart = 6'd2;

	// Data read to buffer MSB clear, in fclk cycles
	localparam logic [3:0] clearDelay = 4'd14;
	// Sync preamble sent ahead of the first buffer byte
	localparam logic [7:0] preambleByte = 8'hFF;

	// Mode register, bit 0 is latch
	typedef struct packed {
		logic spare;
		logic mzReset;
		logic test;
		logic clk8MHz;
		logic fast;
		logic timerOff;
		logic async;
		logic latch;
	} modeFieldsT;

	typedef union packed {
		logic [7:0] raw;
		modeFieldsT fields;
	} modeWordT;

endpackage

//--- iwmControl.sv
`timescale 1ns/1ps

module iwmControl (
	input  logic             fclk,
	input  logic             nRES,
	input  logic [3:0]       addr,
	input  logic             nDeviceSelect,
	input  logic [7:0]       dataIn,
	input  logic             sense,
	input  logic [7:0]       buffer,
	input  logic             bufEmpty,
	input  logic             nUnderrun,
	output logic [7:0]       data,
	output logic [3:0]       phase,
	output logic             nEnbl1,
	output logic             nEnbl2,
	output logic             nWrReq,
	output logic             motorOn,
	output logic             q6,
	output logic             q7,
	output logic             bufWrite,
	output iwmPkg::modeWordT mode,
	output logic             dataRead
);

	import iwmPkg::*;

	logic nDeviceSelectPrev;
	logic driveSelect;
	logic selFall;
	logic regWrite;
	logic enableActive;

	// Falling select edge, start of a new access
	assign selFall = nDeviceSelectPrev & ~nDeviceSelect;

	// Write decode, Q7=Q6=1 with A0=1
	assign regWrite = ~nDeviceSelect & q7 & q6 & addr[0];
	// Motor on turns a register write into a data write
	assign bufWrite = regWrite & motorOn;
	// Data register read, used to start the MSB clear
	assign dataRead = ~nDeviceSelect & ~q7 & ~q6 & ~addr[0];

	// ==========================================================
	// State pseudo-register
	// ==========================================================
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			nDeviceSelectPrev <= 1'b1;
			phase <= 4'b0000;
			motorOn <= 1'b0;
			driveSelect <= 1'b0;
			q6 <= 1'b0;
			q7 <= 1'b0;
		end else begin
			nDeviceSelectPrev <= nDeviceSelect;
			// Phases, motor and drive follow every selected cycle
			if (!nDeviceSelect) begin
				case (addr[3:1])
					regPhase0: phase[0] <= addr[0];
					regPhase1: phase[1] <= addr[0];
					regPhase2: phase[2] <= addr[0];
					regPhase3: phase[3] <= addr[0];
					regMotor: motorOn <= addr[0];
					regDrive: driveSelect <= addr[0];
					default: ;
				endcase
			end
			// Q6 and Q7 only on a fresh access
			// A0 settling inside one access must not flip the mode
			if (selFall) begin
				case (addr[3:1])
					regQ6: q6 <= addr[0];
					regQ7: q7 <= addr[0];
					default: ;
				endcase
			end
		end
	end

	// Mode register, written with the motor off
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			mode.raw <= modeResetValue;
		end else if (regWrite && !motorOn) begin
			mode.raw <= dataIn;
		end
	end

	// ==========================================================
	// Drive enables and write request
	// ==========================================================
	assign nEnbl1 = ~(motorOn & ~driveSelect);
	assign nEnbl2 = ~(motorOn & driveSelect);
	assign enableActive = ~nEnbl1 | ~nEnbl2;

	// Request held only while writing, not starved, drive enabled
	assign nWrReq = ~(q7 & nUnderrun & enableActive);

	// ==========================================================
	// Read multiplexer
	// ==========================================================
	always_comb begin
		case ({q7, q6})
			// Data register
			2'b00: data = buffer;
			// Status: sense, 0, enable active, mode[4:0]
			2'b01: data = {sense, 1'b0, enableActive, mode.raw[4:0]};
			// Write handshake: buffer free, no underrun
			2'b10: data = {bufEmpty, nUnderrun, 6'b000000};
			// Write states have no readback
			default: data = 8'hFF;
		endcase
	end

endmodule

//--- iwmDataBuffer.sv
`timescale 1ns/1ps

module iwmDataBuffer (
	input  logic       fclk,
	input  logic       nRES,
	input  logic       bufWrite,
	input  logic [7:0] dataIn,
	input  logic       byteReady,
	input  logic [7:0] byteOut,
	input  logic       loadReq,
	input  logic       dataRead,
	input  logic       q7,
	input  logic       q6,
	output logic [7:0] buffer,
	output logic       bufEmpty
);

	import iwmPkg::*;

	logic [3:0] clearTimer;
	logic       clearNow;

	// Timer end, only honoured while still in data read mode
	assign clearNow = (clearTimer == clearDelay) & ~q7 & ~q6;

	// ==========================================================
	// Shared byte
	// ==========================================================
	// MSB doubles as the byte-valid flag for the CPU, hence cleared
	// CPU write wins over a reader capture, capture over the clear
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			buffer <= 8'h00;
		end else if (bufWrite) begin
			buffer <= dataIn;
		end else if (byteReady) begin
			buffer <= byteOut;
		end else if (clearNow) begin
			buffer[7] <= 1'b0;
		end
	end

	// Empty once the serializer takes it, full after a CPU write
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			bufEmpty <= 1'b1;
		end else if (bufWrite) begin
			bufEmpty <= 1'b0;
		end else if (loadReq) begin
			bufEmpty <= 1'b1;
		end
	end

	// Counts from the first read that sees a valid byte
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			clearTimer <= 4'd0;
		end else if (q7 || q6) begin
			clearTimer <= 4'd0;
		end else if (clearTimer == 4'd0) begin
			if (dataRead && buffer[7])
				clearTimer <= 4'd1;
		end else if (clearNow) begin
			clearTimer <= 4'd0;
		end else begin
			clearTimer <= clearTimer + 4'd1;
		end
	end

endmodule

//--- iwmReadShifter.sv
`timescale 1ns/1ps

module iwmReadShifter (
	input  logic             fclk,
	input  logic             nRES,
	input  logic             rddata,
	input  logic             q7,
	input  iwmPkg::modeWordT mode,
	output logic             byteReady,
	output logic [7:0]       byteOut
);

	import iwmPkg::*;

	logic [1:0]           rdSync;
	logic                 rdFall;
	logic [bitTimerW-1:0] bitTimer;
	logic [bitTimerW-1:0] oneThresh;
	logic [bitTimerW-1:0] zeroThresh;
	logic [7:0]           shifter;
	logic [7:0]           shiftBase;

	// Bit-cell windows from the speed and clock fields
	always_comb begin
		case ({mode.fields.fast, mode.fields.clk8MHz})
			2'b00: begin
				oneThresh = oneThreshSlow7;
				zeroThresh = zeroThreshSlow7;
			end
			2'b01: begin
				oneThresh = oneThreshSlow8;
				zeroThresh = zeroThreshSlow8;
			end
			2'b10: begin
				oneThresh = oneThreshFast7;
				zeroThresh = zeroThreshFast7;
			end
			default: begin
				oneThresh = oneThreshFast8;
				zeroThresh = zeroThreshFast8;
			end
		endcase
	end

	// Older sample high, newer low
	assign rdFall = rdSync[1] & ~rdSync[0];

	// GCR framing, a byte is complete once its MSB reaches bit 7
	assign byteReady = ~q7 & shifter[7];
	assign byteOut = shifter;
	// Presented byte leaves the shifter in the same cycle
	assign shiftBase = byteReady ? 8'h00 : shifter;

	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			rdSync <= 2'b11;
			bitTimer <= '0;
			shifter <= 8'h00;
		end else begin
			rdSync <= {rdSync[0], rddata};
			if (q7) begin
				// Reader idle while writing
				bitTimer <= '0;
				shifter <= 8'h00;
			end else if (rdFall) begin
				// Early edge restarts the cell but carries no bit
				bitTimer <= '0;
				if (bitTimer >= oneThresh)
					shifter <= {shiftBase[6:0], 1'b1};
				else
					shifter <= shiftBase;
			end else if (bitTimer >= zeroThresh) begin
				// Missing edge, next cell measured from the 1 window
				bitTimer <= oneThresh;
				shifter <= {shiftBase[6:0], 1'b0};
			end else begin
				bitTimer <= bitTimer + 1'b1;
				shifter <= shiftBase;
			end
		end
	end

endmodule

//--- iwmWriteSerializer.sv
`timescale 1ns/1ps

module iwmWriteSerializer (
	input  logic             fclk,
	input  logic             nRES,
	input  logic             q7,
	input  iwmPkg::modeWordT mode,
	input  logic [7:0]       bufData,
	input  logic             bufEmpty,
	output logic             loadReq,
	output logic             nUnderrun,
	output logic             wrdata
);

	import iwmPkg::*;

	logic                 q7Prev;
	logic                 q7Rise;
	logic                 inPreamble;
	logic [bitTimerW-1:0] writeTimer;
	logic [bitTimerW-1:0] writeCell;
	logic [2:0]           bitCount;
	logic [7:0]           shifter;
	logic                 cellEnd;
	logic                 boundary;

	// Cell length from the speed and clock fields
	always_comb begin
		case ({mode.fields.fast, mode.fields.clk8MHz})
			2'b00: writeCell = writeCellSlow7;
			2'b01: writeCell = writeCellSlow8;
			2'b10: writeCell = writeCellFast7;
			default: writeCell = writeCellFast8;
		endcase
	end

	assign q7Rise = q7 & ~q7Prev;
	assign cellEnd = q7 & ~q7Rise & (writeTimer == writeCell);
	// Count of 7 at a cell end marks the byte boundary
	assign boundary = cellEnd & (bitCount == 3'd7);
	// First boundary belongs to the preamble, no buffer fetch
	assign loadReq = boundary & ~inPreamble;

	// ==========================================================
	// Bit timing, underrun and wrdata
	// ==========================================================
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			q7Prev <= 1'b0;
			writeTimer <= '0;
			bitCount <= 3'd7;
			inPreamble <= 1'b0;
			nUnderrun <= 1'b1;
			wrdata <= 1'b0;
		end else begin
			q7Prev <= q7;
			if (!q7) begin
				writeTimer <= '0;
				inPreamble <= 1'b0;
				nUnderrun <= 1'b1;
				wrdata <= 1'b0;
			end else if (q7Rise) begin
				writeTimer <= writeTimerStart;
				bitCount <= 3'd7;
				inPreamble <= 1'b1;
			end else begin
				if (cellEnd) begin
					writeTimer <= '0;
					// 7 rolls over to 0 after a boundary
					bitCount <= bitCount + 3'd1;
					if (boundary)
						inPreamble <= 1'b0;
					// Starved, sticks until Q7 drops
					if (loadReq && bufEmpty)
						nUnderrun <= 1'b0;
				end else begin
					writeTimer <= writeTimer + 1'b1;
				end
				// One transition per 1 bit, early in the cell
				if (writeTimer == bitTimerW'(1) && shifter[7])
					wrdata <= ~wrdata;
			end
		end
	end

	// Output shifter
	always_ff @(posedge fclk) begin
		if (q7Rise) begin
			shifter <= preambleByte;
		end else if (boundary) begin
			if (inPreamble)
				shifter <= preambleByte;
			else if (!bufEmpty)
				shifter <= bufData;
			else
				shifter <= 8'h00;
		end else if (cellEnd) begin
			shifter <= {shifter[6:0], 1'b0};
		end
	end

endmodule

//--- iwm.sv
`timescale 1ns/1ps

module iwm (
	input  logic       fclk,
	input  logic       nRES,
	// CPU bus side
	input  logic [3:0] addr,
	input  logic       nDeviceSelect,
	input  logic [7:0] dataIn,
	output logic [7:0] data,
	// Drive side
	output logic       wrdata,
	output logic [3:0] phase,
	output logic       nWrReq,
	output logic       nEnbl1,
	output logic       nEnbl2,
	input  logic       sense,
	input  logic       rddata
);

	import iwmPkg::*;

	// Shared data byte and its flags
	logic [7:0] buffer;
	logic       bufEmpty;
	logic       bufWrite;
	logic       dataRead;
	// Pseudo-register state fanned out to the serial paths
	logic       motorOn;
	logic       q6;
	logic       q7;
	modeWordT   mode;
	// Reader to buffer
	logic       byteReady;
	logic [7:0] byteOut;
	// Serializer to buffer and back
	logic       loadReq;
	logic       nUnderrun;

	iwmControl control (
		.fclk(fclk), .nRES(nRES), .addr(addr), .nDeviceSelect(nDeviceSelect),
		.dataIn(dataIn), .sense(sense), .buffer(buffer), .bufEmpty(bufEmpty),
		.nUnderrun(nUnderrun), .data(data), .phase(phase), .nEnbl1(nEnbl1),
		.nEnbl2(nEnbl2), .nWrReq(nWrReq), .motorOn(motorOn), .q6(q6), .q7(q7),
		.bufWrite(bufWrite), .mode(mode), .dataRead(dataRead)
	);

	iwmDataBuffer dataBuffer (
		.fclk(fclk), .nRES(nRES), .bufWrite(bufWrite), .dataIn(dataIn),
		.byteReady(byteReady), .byteOut(byteOut), .loadReq(loadReq),
		.dataRead(dataRead), .q7(q7), .q6(q6), .buffer(buffer), .bufEmpty(bufEmpty)
	);

	iwmReadShifter readShifter (
		.fclk(fclk), .nRES(nRES), .rddata(rddata), .q7(q7), .mode(mode),
		.byteReady(byteReady), .byteOut(byteOut)
	);

	iwmWriteSerializer writeSerializer (
		.fclk(fclk), .nRES(nRES), .q7(q7), .mode(mode), .bufData(buffer),
		.bufEmpty(bufEmpty), .loadReq(loadReq), .nUnderrun(nUnderrun), .wrdata(wrdata)
	);

endmodule

//--- iwm_sva.sv
`timescale 1ns/1ps

module iwmSva (
	input logic fclk,
	input logic nRES,
	input logic q7,
	input logic wrdata,
	input logic nWrReq,
	input logic nEnbl1,
	input logic nEnbl2
);

	// ==========================================================
	// Drive side rules
	// ==========================================================
	// Only one drive may be enabled at a time
	enableExclusive: assert property (@(posedge fclk) disable iff (!nRES)
		!(!nEnbl1 && !nEnbl2))
		else $error("nEnbl1 and nEnbl2 low together");

	// A write request only exists in write mode
	wrReqNeedsQ7: assert property (@(posedge fclk) disable iff (!nRES)
		!nWrReq |-> q7)
		else $error("nWrReq low while Q7 is low");

	// Serializer parks wrdata one cycle after Q7 drops
	wrdataIdle: assert property (@(posedge fclk) disable iff (!nRES)
		(!q7 && $past(!q7)) |-> !wrdata)
		else $error("wrdata high while Q7 is low");

endmodule

bind iwm iwmSva iwmSvaInst (
	.fclk(fclk), .nRES(nRES), .q7(q7), .wrdata(wrdata),
	.nWrReq(nWrReq), .nEnbl1(nEnbl1), .nEnbl2(nEnbl2)
);

//--- iwmTb.sv
`timescale 1ns/1ps

module iwmTb;

	// Bus codes, addr[3:1] picks the state bit and addr[0] is its new value
	localparam logic [3:0] addrMotorOff = 4'h8;
	localparam logic [3:0] addrMotorOn = 4'h9;
	localparam logic [3:0] addrDrive1 = 4'hA;
	localparam logic [3:0] addrDrive2 = 4'hB;
	localparam logic [3:0] addrQ6Lo = 4'hC;
	localparam logic [3:0] addrQ6Hi = 4'hD;
	localparam logic [3:0] addrQ7Lo = 4'hE;
	localparam logic [3:0] addrQ7Hi = 4'hF;
	// Latch, async and timer-off, slow 7 MHz timing
	localparam logic [7:0] resetMode = 8'h07;

	localparam int clkPeriod = 20;
	localparam int accessCycles = 4;
	// Slow 7 MHz bit cell
	localparam int cellCycles = 28;
	localparam int readPollMax = 40;
	localparam int writePollMax = 200;
	// Longer than the MSB clear delay plus three
	localparam int clearWait = 18;
	// Worst-case length of each test in fclk cycles
	localparam int modeWorst = 8 * accessCycles;
	localparam int phaseWorst = 16 * accessCycles;
	localparam int latchWorst = 8 * accessCycles;
	localparam int readWorst = 16 + 8 * cellCycles + (readPollMax + 1) * accessCycles + clearWait;
	localparam int writeWorst = (writePollMax + 5) * accessCycles;
	localparam int watchdogCycles = 6 + modeWorst + phaseWorst + latchWorst + readWorst
		+ writeWorst + 100;

	logic       fclk = 1'b0;
	logic       nRES;
	logic [3:0] addr;
	logic       nDeviceSelect;
	logic [7:0] dataIn;
	logic [7:0] data;
	logic       wrdata;
	logic [3:0] phase;
	logic       nWrReq;
	logic       nEnbl1;
	logic       nEnbl2;
	logic       sense;
	logic       rddata;

	int         errorCount;
	int         checkCount;
	int         toggleCount;
	logic       countToggles;
	logic       wrdataLast;
	logic [31:0] seedValue;

	iwm iwm_inst (
		.fclk(fclk), .nRES(nRES), .addr(addr), .nDeviceSelect(nDeviceSelect),
		.dataIn(dataIn), .data(data), .wrdata(wrdata), .phase(phase), .nWrReq(nWrReq),
		.nEnbl1(nEnbl1), .nEnbl2(nEnbl2), .sense(sense), .rddata(rddata)
	);

	always #(clkPeriod / 2) fclk = ~fclk;

	// wrdata moves on the rising edge, so the falling edge sees it settled
	always @(negedge fclk) begin
		if (countToggles && wrdata !== wrdataLast)
			toggleCount = toggleCount + 1;
		wrdataLast = wrdata;
	end

	// ==========================================================
	// Helpers
	// ==========================================================
	task automatic step(input int n);
		repeat (n) @(posedge fclk);
		#2;
	endtask

	// Select low for three edges, data sampled just after the last one
	task automatic busAccess(input logic [3:0] a, input logic [7:0] d, output logic [7:0] rd);
		addr = a;
		dataIn = d;
		nDeviceSelect = 1'b0;
		repeat (3) @(posedge fclk);
		#1 rd = data;
		#1 nDeviceSelect = 1'b1;
		// One deselected edge so the next access counts as fresh
		step(1);
	endtask

	task automatic checkValue(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERR %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("%s", what);
	endtask

	// Status layout: sense, 0, enable active, mode bits 4 to 0
	function automatic logic [7:0] statusOf(input logic senseBit, input logic enabled,
		input logic [7:0] modeVal);
		return {senseBit, 1'b0, enabled, modeVal[4:0]};
	endfunction

	function automatic int countOnes(input logic [7:0] v);
		int n;
		int k;
		n = 0;
		for (k = 0; k < 8; k++)
			n += v[k];
		return n;
	endfunction

	// ==========================================================
	// Directed tests
	// ==========================================================
	task automatic resetAndMode();
		logic [7:0] rd;
		logic [7:0] modeVal;
		modeVal = 8'($urandom());
		busAccess(addrQ6Hi, 8'h00, rd);
		checkValue("data (status after reset)", rd, statusOf(sense, 1'b0, resetMode));
		// Q7 rising with Q6 set and motor off loads the mode register
		busAccess(addrQ7Hi, modeVal, rd);
		busAccess(addrQ7Lo, 8'h00, rd);
		busAccess(addrQ6Hi, 8'h00, rd);
		checkValue("data (status after mode write)", rd, statusOf(sense, 1'b0, modeVal));
		// Back to slow 7 MHz for the serial tests
		busAccess(addrQ7Hi, resetMode, rd);
		busAccess(addrQ7Lo, 8'h00, rd);
		busAccess(addrQ6Lo, 8'h00, rd);
	endtask

	task automatic phasesAndEnables();
		logic [7:0] rd;
		logic [3:0] expPhase;
		logic       setBit;
		int         i;
		expPhase = 4'h0;
		// First pass sets phases 0 to 3, second pass clears them
		for (i = 0; i < 8; i++) begin
			setBit = (i < 4);
			busAccess({3'(i % 4), setBit}, 8'h00, rd);
			expPhase[i % 4] = setBit;
			checkValue("phase", {4'h0, phase}, {4'h0, expPhase});
		end
		busAccess(addrMotorOn, 8'h00, rd);
		busAccess(addrDrive1, 8'h00, rd);
		checkValue("nEnbl2,nEnbl1", {6'd0, nEnbl2, nEnbl1}, 8'h02);
		busAccess(addrQ6Hi, 8'h00, rd);
		checkValue("data (status, drive on)", rd, statusOf(sense, 1'b1, resetMode));
		busAccess(addrQ6Lo, 8'h00, rd);
		busAccess(addrDrive2, 8'h00, rd);
		checkValue("nEnbl2,nEnbl1", {6'd0, nEnbl2, nEnbl1}, 8'h01);
		busAccess(addrMotorOff, 8'h00, rd);
		checkValue("nEnbl2,nEnbl1", {6'd0, nEnbl2, nEnbl1}, 8'h03);
		busAccess(addrDrive1, 8'h00, rd);
	endtask

	task automatic q7EdgeLatch();
		logic [7:0] rd;
		busAccess(addrQ6Hi, 8'h00, rd);
		// A0 rises while select stays low, Q7 keeps its value
		addr = addrQ7Lo;
		dataIn = resetMode;
		nDeviceSelect = 1'b0;
		step(1);
		addr = addrQ7Hi;
		repeat (2) @(posedge fclk);
		#1 rd = data;
		#1 nDeviceSelect = 1'b1;
		step(1);
		checkValue("data (Q7 held)", rd, statusOf(sense, 1'b0, resetMode));
		// Fresh access sets Q7, mode rewritten with its own value
		busAccess(addrQ7Hi, resetMode, rd);
		checkValue("data (Q7 Q6 set)", rd, 8'hFF);
		busAccess(addrQ7Lo, 8'h00, rd);
		busAccess(addrQ6Lo, 8'h00, rd);
	endtask

	task automatic diskRead();
		logic [7:0] rd;
		logic [7:0] readByte;
		int         b;
		int         tries;
		readByte = 8'($urandom()) | 8'h80;
		// Let the reader timer pass the 1 window first
		step(16);
		// Low pulse opens each cell that carries a 1
		for (b = 7; b >= 0; b--) begin
			rddata = ~readByte[b];
			step(4);
			rddata = 1'b1;
			step(cellCycles - 4);
		end
		rd = 8'h00;
		tries = 0;
		while (!rd[7] && tries < readPollMax) begin
			busAccess(addrQ6Lo, 8'h00, rd);
			tries++;
		end
		if (!rd[7])
			reportFailure("Disk read: no byte with bit 7 set reached the data register");
		else
			checkValue("data (disk byte)", rd, readByte);
		step(clearWait);
		busAccess(addrQ6Lo, 8'h00, rd);
		checkValue("data (after MSB clear)", rd, readByte & 8'h7F);
	endtask

	task automatic diskWrite();
		logic [7:0] rd;
		logic [7:0] writeByte;
		logic       sawRequest;
		int         tries;
		writeByte = 8'($urandom());
		busAccess(addrMotorOn, 8'h00, rd);
		busAccess(addrQ6Hi, 8'h00, rd);
		toggleCount = 0;
		countToggles = 1'b1;
		// Motor on, so Q7 rising here also writes the buffer
		busAccess(addrQ7Hi, writeByte, rd);
		sawRequest = 1'b0;
		rd = 8'h40;
		tries = 0;
		// Handshake register, bit 6 drops on underrun
		while (rd[6] && tries < writePollMax) begin
			busAccess(addrQ6Lo, 8'h00, rd);
			if (rd[6] && !nWrReq)
				sawRequest = 1'b1;
			tries++;
		end
		if (rd[6]) begin
			reportFailure("Disk write: underrun never showed in the handshake register");
		end else begin
			checkValue("data[7] (buffer empty)", {7'd0, rd[7]}, 8'h01);
			checkValue("nWrReq (after underrun)", {7'd0, nWrReq}, 8'h01);
			checkValue("nWrReq low seen before underrun", {7'd0, sawRequest}, 8'h01);
			// Preamble FF gives 8, then one per 1 bit of the byte
			checkValue("wrdata toggles", 8'(toggleCount), 8'(8 + countOnes(writeByte)));
		end
		countToggles = 1'b0;
		busAccess(addrQ7Lo, 8'h00, rd);
		busAccess(addrMotorOff, 8'h00, rd);
	endtask

	// ==========================================================
	// Sequencing and watchdog
	// ==========================================================
	initial begin
		seedValue = $urandom(32'hd3c);
		nRES = 1'b0;
		addr = 4'h0;
		nDeviceSelect = 1'b1;
		dataIn = 8'h00;
		rddata = 1'b1;
		sense = 1'($urandom());
		errorCount = 0;
		checkCount = 0;
		toggleCount = 0;
		countToggles = 1'b0;
		repeat (4) @(posedge fclk);
		#2 nRES = 1'b1;
		step(2);
		resetAndMode();
		phasesAndEnables();
		q7EdgeLatch();
		diskRead();
		diskWrite();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout: tests still running after %0d cycles", watchdogCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- src.f
iwmPkg.sv
iwmControl.sv
iwmDataBuffer.sv
iwmReadShifter.sv
iwmWriteSerializer.sv
iwm.sv
iwm_sva.sv
iwmTb.sv
